// ==== fetchq_macros.svh ====
`ifndef FETCHQ_MACROS_SVH
`define FETCHQ_MACROS_SVH

// queue geometry
// number of entries, any depth from 1 up, power of two not needed
`define FQ_DEPTH 8

// width of pc and of the instruction word
`define FQ_XLEN 32

// occupancy count, must hold 0 .. FQ_DEPTH inclusive
`define FQ_CNT_W ($clog2(`FQ_DEPTH + 1))

// pointer and ram address width, never below one bit
`define FQ_ADDR_W ((`FQ_DEPTH > 1) ? $clog2(`FQ_DEPTH) : 1)

`endif

// ==== fetchq_pkg.sv ====
`default_nettype none

`include "fetchq_macros.svh"

package fetchq_pkg;

  // =========================================================================
  // opcodes recognised by the predecoder
  // =========================================================================
  parameter logic [6:0] OPC_BRANCH = 7'b1100011;
  parameter logic [6:0] OPC_JALR   = 7'b1100111;

  // one queue entry as pushed by fetch
  typedef struct packed {
    logic [`FQ_XLEN-1:0] pc;
    logic [`FQ_XLEN-1:0] inst;
  } fetch_entry_t;

  // i-type layout, immediate in one piece
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_t;

  // b-type layout, immediate scattered over two fields pairs
  typedef struct packed {
    logic        imm12;
    logic [5:0]  imm10_5;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [3:0]  imm4_1;
    logic        imm11;
    logic [6:0]  opcode;
  } btype_t;

  // same word, two views; opcode sits in the same bits in both
  typedef union packed {
    itype_t itype;
    btype_t btype;
  } inst_word_t;

  typedef enum logic [1:0] {
    CLASS_OTHER  = 2'd0,
    CLASS_BRANCH = 2'd1,
    CLASS_JUMP   = 2'd2
  } inst_class_e;

  // downstream payload to decode
  typedef struct packed {
    logic [`FQ_XLEN-1:0] pc;
    logic [`FQ_XLEN-1:0] inst;
    inst_class_e         inst_class;
    logic [`FQ_XLEN-1:0] imm;
  } decoded_inst_t;

endpackage

`default_nettype wire

// ==== sdp_ram.sv ====
`default_nettype none

`include "fetchq_macros.svh"

module sdp_ram
  import fetchq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  we_i,
  input  logic [`FQ_ADDR_W-1:0] waddr_i,
  input  fetch_entry_t          wdata_i,
  input  logic [`FQ_ADDR_W-1:0] raddr_i,
  output fetch_entry_t          rdata_o
);

  // storage array
  fetch_entry_t mem [`FQ_DEPTH];
  // read port output register
  fetch_entry_t rdata_q;

  // write port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // registered read port
  // write-first, same-cycle write to the read address wins
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (we_i && (waddr_i == raddr_i)) begin
      rdata_q <= wdata_i;
    end else begin
      rdata_q <= mem[raddr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== sync_fifo.sv ====
`default_nettype none

`include "fetchq_macros.svh"

module sync_fifo
  import fetchq_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush_i,
  input  logic                 push_i,
  input  fetch_entry_t         data_i,
  input  logic                 pop_i,
  output fetch_entry_t         data_o,
  output logic                 empty_o,
  output logic                 full_o,
  output logic [`FQ_CNT_W-1:0] usage_o
);

  localparam int unsigned ADDR_W = `FQ_ADDR_W;
  localparam int unsigned CNT_W  = `FQ_CNT_W;
  // last valid slot, pointers wrap here
  localparam logic [ADDR_W-1:0] LAST_IDX = ADDR_W'(`FQ_DEPTH - 1);
  localparam logic [CNT_W-1:0]  FULL_CNT = CNT_W'(`FQ_DEPTH);

  // =========================================================================
  // state
  // =========================================================================
  logic [ADDR_W-1:0] rd_ptr_q;
  logic [ADDR_W-1:0] rd_ptr_n;
  logic [ADDR_W-1:0] wr_ptr_q;
  logic [ADDR_W-1:0] wr_ptr_n;
  logic [CNT_W-1:0]  cnt_q;
  logic [CNT_W-1:0]  cnt_n;

  logic              ram_we;
  fetch_entry_t      ram_rdata;
  logic              push_ok;
  logic              pop_ok;
  logic              bypass;

  // ram read address is the next read pointer,
  // so the new head is already registered after the edge
  sdp_ram u_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (ram_we),
    .waddr_i (wr_ptr_q),
    .wdata_i (data_i),
    .raddr_i (rd_ptr_n),
    .rdata_o (ram_rdata)
  );

  // =========================================================================
  // status
  // =========================================================================
  assign full_o  = (cnt_q == FULL_CNT);
  // fall-through, push into empty queue counts as not empty
  assign empty_o = (cnt_q == '0) && !push_i;
  assign usage_o = cnt_q;

  assign bypass  = (cnt_q == '0) && push_i;
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  // next-state pointers and count
  always_comb begin
    rd_ptr_n = rd_ptr_q;
    wr_ptr_n = wr_ptr_q;
    ram_we   = 1'b0;
    data_o   = ram_rdata;

    if (push_ok) begin
      ram_we   = 1'b1;
      // explicit wrap, works for any depth
      wr_ptr_n = (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
    end

    if (pop_ok) begin
      rd_ptr_n = (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
    end

    // push and pop together leave the count alone
    case ({push_ok, pop_ok})
      2'b10:   cnt_n = cnt_q + 1'b1;
      2'b01:   cnt_n = cnt_q - 1'b1;
      default: cnt_n = cnt_q;
    endcase

    // empty queue, incoming word goes straight to the head
    if (bypass) begin
      data_o = data_i;
      // taken in the same cycle, nothing is stored
      if (pop_i) begin
        ram_we   = 1'b0;
        rd_ptr_n = rd_ptr_q;
        wr_ptr_n = wr_ptr_q;
        cnt_n    = cnt_q;
      end
    end
  end

  // flush beats push and pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      rd_ptr_q <= rd_ptr_n;
      wr_ptr_q <= wr_ptr_n;
      cnt_q    <= cnt_n;
    end
  end

endmodule

`default_nettype wire

// ==== predecode.sv ====
`default_nettype none

`include "fetchq_macros.svh"

module predecode
  import fetchq_pkg::*;
(
  input  fetch_entry_t  entry_i,
  output decoded_inst_t dec_o
);

  // =========================================================================
  // instruction views
  // =========================================================================
  inst_word_t              iw;
  logic [6:0]              opcode;
  logic [`FQ_XLEN-1:0]     imm_b;
  logic [`FQ_XLEN-1:0]     imm_i;
  inst_class_e             cls;
  logic [`FQ_XLEN-1:0]     imm;

  assign iw     = entry_i.inst;
  // opcode field is shared by both layouts
  assign opcode = iw.itype.opcode;

  // b-type immediate, reassembled, bit 0 always zero
  assign imm_b = {
    {(`FQ_XLEN - 12){iw.btype.imm12}},
    iw.btype.imm11,
    iw.btype.imm10_5,
    iw.btype.imm4_1,
    1'b0
  };

  // i-type immediate, sign extended
  assign imm_i = {{(`FQ_XLEN - 12){iw.itype.imm[11]}}, iw.itype.imm};

  // =========================================================================
  // classification
  // =========================================================================
  always_comb begin
    case (opcode)
      OPC_BRANCH: begin
        cls = CLASS_BRANCH;
        imm = imm_b;
      end
      OPC_JALR: begin
        cls = CLASS_JUMP;
        imm = imm_i;
      end
      default: begin
        // no target for anything else
        cls = CLASS_OTHER;
        imm = '0;
      end
    endcase
  end

  // pc and raw word go through untouched
  assign dec_o.pc         = entry_i.pc;
  assign dec_o.inst       = entry_i.inst;
  assign dec_o.inst_class = cls;
  assign dec_o.imm        = imm;

endmodule

`default_nettype wire

// ==== fetchq_top.sv ====
`default_nettype none

module fetchq_top
  import fetchq_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          flush_i,
  input  logic          push_i,
  input  fetch_entry_t  push_entry_i,
  output logic          credit_o,
  output logic          out_valid_o,
  input  logic          out_ready_i,
  output decoded_inst_t out_inst_o
);

  logic         fifo_push;
  logic         fifo_empty;
  logic         xfer;
  fetch_entry_t head;
  logic         credit_q;

  // =========================================================================
  // upstream side
  // =========================================================================
  // push during a redirect is dropped
  assign fifo_push = push_i && !flush_i;

  // full and usage unused, fetch credits bound the occupancy
  sync_fifo u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .push_i  (fifo_push),
    .data_i  (push_entry_i),
    .pop_i   (xfer),
    .data_o  (head),
    .empty_o (fifo_empty),
    .full_o  (),
    .usage_o ()
  );

  // =========================================================================
  // downstream side
  // =========================================================================
  // head is hidden while flushing
  assign out_valid_o = !fifo_empty && !flush_i;
  // handshake, also the fifo pop
  assign xfer        = out_valid_o && out_ready_i;

  // combinational classify of the head
  predecode u_predecode (
    .entry_i (head),
    .dec_o   (out_inst_o)
  );

  // one credit back, one cycle after every entry that leaves
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= xfer;
    end
  end

  assign credit_o = credit_q;

endmodule

`default_nettype wire

// ==== tb_fetchq.sv ====
`default_nettype none

`include "fetchq_macros.svh"

module tb_fetchq
  import fetchq_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // =========================================================================
  // run length and traffic mix
  // =========================================================================
  localparam int RESET_CYCLES = 4;
  localparam int RAND_CYCLES  = 2000;
  localparam int FT_COUNT     = 16;
  localparam int FT_CYCLES    = 2 * FT_COUNT + 2;
  localparam int BP_CYCLES    = `FQ_DEPTH + 2;
  localparam int FL_CYCLES    = 16;
  localparam int DRAIN_CYCLES = `FQ_DEPTH + 4;
  localparam int TOTAL_CYCLES = RESET_CYCLES + RAND_CYCLES + FT_CYCLES + BP_CYCLES
                                + FL_CYCLES + 3 * DRAIN_CYCLES;
  // twice the test length in ns
  localparam longint WATCHDOG_NS = longint'(TOTAL_CYCLES) * 2 * 100;
  localparam int READY_PCT = 70;
  localparam int PUSH_PCT  = 60;

  logic          clk;
  logic          rst_n;
  logic          flush_i;
  logic          push_i;
  fetch_entry_t  push_entry_i;
  logic          credit_o;
  logic          out_valid_o;
  logic          out_ready_i;
  decoded_inst_t out_inst_o;

  // model state
  fetch_entry_t model_q[$];
  int           credits;
  logic         xfer_prev;
  int           errors;
  int           tests_run;
  int           tests_failed;
  int           transfers;
  int           credit_pulses;

  fetchq_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .push_i       (push_i),
    .push_entry_i (push_entry_i),
    .credit_o     (credit_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_inst_o   (out_inst_o)
  );

  always #50 clk = ~clk;

  // expected predecode from the riscv field layouts
  function automatic decoded_inst_t expect_decode(input fetch_entry_t e);
    decoded_inst_t       d;
    logic [`FQ_XLEN-1:0] w;
    w            = e.inst;
    d.pc         = e.pc;
    d.inst       = e.inst;
    d.inst_class = CLASS_OTHER;
    d.imm        = '0;
    if (w[6:0] == OPC_BRANCH) begin
      d.inst_class = CLASS_BRANCH;
      d.imm        = {{(`FQ_XLEN - 12){w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    end else if (w[6:0] == OPC_JALR) begin
      d.inst_class = CLASS_JUMP;
      d.imm        = {{(`FQ_XLEN - 12){w[31]}}, w[31:20]};
    end
    return d;
  endfunction

  // word aligned pc with a branch, jalr or random opcode
  function automatic fetch_entry_t rand_entry();
    fetch_entry_t e;
    int           pick;
    pick   = $urandom_range(0, 2);
    e.pc   = $urandom & ~32'h3;
    e.inst = $urandom;
    if (pick == 0) begin
      e.inst[6:0] = OPC_BRANCH;
    end else if (pick == 1) begin
      e.inst[6:0] = OPC_JALR;
    end
    return e;
  endfunction

  // =========================================================================
  // compare tasks
  // =========================================================================
  task automatic compare_inst(input decoded_inst_t got, input decoded_inst_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: head pc %h inst %h class %0d imm %h", $time,
               got.pc, got.inst, got.inst_class, got.imm);
      $display("  expected pc %h inst %h class %0d imm %h",
               exp.pc, exp.inst, exp.inst_class, exp.imm);
    end
  endtask

  task automatic compare_credit(input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: credit_o %b, expected %b", $time, got, exp);
    end
    if (got === 1'b1) begin
      credit_pulses++;
    end
  endtask

  task automatic compare_valid(input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: out_valid_o %b, expected %b", $time, got, exp);
    end
  endtask

  // one clock with drive after the edge and checks at the falling edge
  task automatic run_cycle(input logic push, input fetch_entry_t entry,
                           input logic ready, input logic flush);
    @(posedge clk);
    #1;
    push_i       = push;
    push_entry_i = entry;
    out_ready_i  = ready;
    flush_i      = flush;
    @(negedge clk);
    compare_credit(credit_o, xfer_prev);
    if (flush) begin
      // redirect drops the push and restores the credits
      compare_valid(out_valid_o, 1'b0);
      model_q.delete();
      credits   = `FQ_DEPTH;
      xfer_prev = 1'b0;
    end else begin
      if (credit_o === 1'b1) begin
        credits++;
      end
      if (push) begin
        model_q.push_back(entry);
        credits--;
        if (credits < 0) begin
          errors++;
          $display("at %0t the fetch side pushed with no credit left", $time);
        end
      end
      compare_valid(out_valid_o, model_q.size() > 0);
      if (model_q.size() > 0) begin
        compare_inst(out_inst_o, expect_decode(model_q[0]));
      end
      // handshake as the model sees it
      xfer_prev = (model_q.size() > 0) && ready;
      if (xfer_prev) begin
        void'(model_q.pop_front());
        transfers++;
      end
    end
  endtask

  // empty the queue and wait for the last credit
  task automatic drain(input int budget);
    int n;
    n = 0;
    while ((model_q.size() != 0 || xfer_prev) && n < budget) begin
      run_cycle(1'b0, '0, 1'b1, 1'b0);
      n++;
    end
    if (model_q.size() != 0) begin
      errors++;
      $display("at %0t the queue did not drain within %0d cycles", $time, budget);
    end
    if (credits != `FQ_DEPTH) begin
      errors++;
      $display("Mismatch at %0t: credits %0d after drain, expected %0d",
               $time, credits, `FQ_DEPTH);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // =========================================================================
  // tests
  // =========================================================================
  initial begin
    int   e0;
    logic push;
    clk           = 1'b0;
    rst_n         = 1'b0;
    flush_i       = 1'b0;
    push_i        = 1'b0;
    push_entry_i  = '0;
    out_ready_i   = 1'b0;
    model_q.delete();
    credits       = `FQ_DEPTH;
    xfer_prev     = 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    transfers     = 0;
    credit_pulses = 0;
    void'($urandom(32'h2a9d));

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // mixed traffic with an occasional redirect
    e0 = errors;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      push = (credits > 0) && ($urandom_range(0, 99) < PUSH_PCT);
      run_cycle(push, rand_entry(), $urandom_range(0, 99) < READY_PCT,
                $urandom_range(0, 39) == 0);
    end
    drain(DRAIN_CYCLES);
    report_test("random_traffic", e0);

    // push into the empty queue is taken in the same cycle
    e0 = errors;
    run_cycle(1'b0, '0, 1'b1, 1'b1);
    for (int i = 0; i < FT_COUNT; i++) begin
      run_cycle(1'b1, rand_entry(), 1'b1, 1'b0);
      run_cycle(1'b0, '0, 1'b1, 1'b0);
      if (credits != `FQ_DEPTH) begin
        errors++;
        $display("Mismatch at %0t: credits %0d after a fall-through transfer, expected %0d",
                 $time, credits, `FQ_DEPTH);
      end
    end
    report_test("fall_through", e0);

    // decode stalls until fetch runs out of credits
    e0 = errors;
    run_cycle(1'b0, '0, 1'b0, 1'b1);
    for (int i = 0; i < `FQ_DEPTH; i++) begin
      run_cycle(1'b1, rand_entry(), 1'b0, 1'b0);
    end
    run_cycle(1'b0, '0, 1'b0, 1'b0);
    if (credits != 0) begin
      errors++;
      $display("Mismatch at %0t: credits %0d with decode stalled, expected 0",
               $time, credits);
    end
    drain(DRAIN_CYCLES);
    report_test("back_pressure", e0);

    // old entries gone after a redirect
    e0 = errors;
    run_cycle(1'b0, '0, 1'b0, 1'b1);
    for (int i = 0; i < 5; i++) begin
      run_cycle(1'b1, rand_entry(), 1'b0, 1'b0);
    end
    // push in the flush cycle is dropped
    run_cycle(1'b1, rand_entry(), 1'b1, 1'b1);
    repeat (6) run_cycle(1'b0, '0, 1'b1, 1'b0);
    run_cycle(1'b1, rand_entry(), 1'b1, 1'b0);
    drain(DRAIN_CYCLES);
    report_test("flush", e0);

    $display("tests %0d, failed %0d, errors %0d, transfers %0d, credit pulses %0d",
             tests_run, tests_failed, errors, transfers, credit_pulses);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fetchq.f ====
+incdir+.
fetchq_pkg.sv
sdp_ram.sv
sync_fifo.sv
predecode.sv
fetchq_top.sv
tb_fetchq.sv

// ==== Makefile ====
# Verilator simulation of the fetch queue

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_fetchq
FILELIST  = fetchq.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
